// ==== design/soc_map_pkg.sv ====
/* I/O region address map, word slot numbers, clock rate,
   display resolution and reset values of the I/O block */

package soc_map_pkg;

    // region decode
    localparam logic [3:0] IO_REGION = 4'hE;    // addr[31:28] of the I/O space

    // word slots, addr[6:2]
    localparam logic [4:0] SLOT_MS        = 5'd0;   // millisecond counter
    localparam logic [4:0] SLOT_LED       = 5'd1;   // led register
    localparam logic [4:0] SLOT_UART_DATA = 5'd2;   // rx byte / tx start
    localparam logic [4:0] SLOT_UART_CTRL = 5'd3;   // uart status / dequeue
    localparam logic [4:0] SLOT_SPI_DATA  = 5'd4;   // spi rx word / spi start
    localparam logic [4:0] SLOT_SPI_CTRL  = 5'd5;   // spi status / slave selects
    localparam logic [4:0] SLOT_GFX_CMD   = 5'd8;   // drawing engine command port
    localparam logic [4:0] SLOT_RES_FLUSH = 5'd9;   // resolution / cache flush
    localparam logic [4:0] SLOT_FB_ADDR   = 5'd10;  // frame buffer base
    localparam logic [4:0] SLOT_VSYNC     = 5'd11;  // vertical sync status

    // timing
    localparam int CLK_FREQ_HZ  = 10_000_000;
    localparam int TICKS_PER_MS = CLK_FREQ_HZ / 1000;
    localparam int TICK_W       = $clog2(TICKS_PER_MS);   // sub-ms counter width

    // fixed 640x480 display
    localparam logic [15:0] H_RES = 16'd640;
    localparam logic [15:0] V_RES = 16'd480;

    // reset values
    localparam logic [31:0] DEFAULT_FB_ADDR = 32'h0100_0000;

    // receive queue size
    localparam int RXQ_DEPTH_LOG2 = 4;
    localparam int RXQ_DEPTH      = 1 << RXQ_DEPTH_LOG2;

endpackage

// ==== design/soc_bus_pkg.sv ====
/* signal groups of the I/O block: CPU bus request, decoded
   write strobes, readback status and control outputs */

package soc_bus_pkg;

    // one CPU bus request, valid for a single cycle when sel is set
    typedef struct packed {
        logic        sel;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } io_req_t;

    // write strobes, one per writable slot
    typedef struct packed {
        logic        we_led;
        logic        we_uart_data;   // tx start
        logic        we_uart_ctrl;   // rx dequeue
        logic        we_spi_data;    // spi start
        logic        we_spi_ctrl;
        logic        we_gfx_cmd;
        logic        we_res_flush;
        logic        we_fb_addr;
        logic [31:0] wdata;
    } io_wr_t;

    // levels read back by the CPU
    typedef struct packed {
        logic [31:0] ms_count;
        logic [7:0]  rx_byte;
        logic        rx_ready;
        logic        tx_ready;
        logic [31:0] spi_rx;
        logic        spi_ready;
        logic        gfx_ready;
        logic        vsync;
    } io_status_t;

    // registered control outputs
    typedef struct packed {
        logic [7:0]  led;
        logic [1:0]  spi_ss_n;       // active low slave selects
        logic        spi_fast;
        logic [31:0] gfx_cmd_data;
        logic        gfx_cmd_valid;
        logic        flush;
        logic [31:0] frame_base;
    } ctrl_out_t;

endpackage

// ==== design/io_bus_port.sv ====
/* bus port of the I/O block: region check, per-slot write
   strobes and the combinational read data mux */

`timescale 1ns/1ps

module io_bus_port
    import soc_map_pkg::*, soc_bus_pkg::*;
(
    input  io_req_t     io_req_i,
    input  io_status_t  status_i,
    output io_wr_t      io_wr_o,
    output logic [31:0] rdata_o
);

    logic       io_hit;     // request falls in the I/O region
    logic       wr_en;
    logic [4:0] slot;       // word address

    assign io_hit = io_req_i.sel && (io_req_i.addr[31:28] == IO_REGION);
    assign wr_en  = io_hit && io_req_i.we;
    assign slot   = io_req_i.addr[6:2];

    always_comb begin
        io_wr_o.we_led       = wr_en && (slot == SLOT_LED);
        io_wr_o.we_uart_data = wr_en && (slot == SLOT_UART_DATA);
        io_wr_o.we_uart_ctrl = wr_en && (slot == SLOT_UART_CTRL);
        io_wr_o.we_spi_data  = wr_en && (slot == SLOT_SPI_DATA);
        io_wr_o.we_spi_ctrl  = wr_en && (slot == SLOT_SPI_CTRL);
        io_wr_o.we_gfx_cmd   = wr_en && (slot == SLOT_GFX_CMD);
        io_wr_o.we_res_flush = wr_en && (slot == SLOT_RES_FLUSH);
        io_wr_o.we_fb_addr   = wr_en && (slot == SLOT_FB_ADDR);
        io_wr_o.wdata        = io_req_i.wdata;

        // downstream registers assume a single target per request
        a_one_strobe: assert final ($onehot0({io_wr_o.we_led, io_wr_o.we_uart_data,
                                              io_wr_o.we_uart_ctrl, io_wr_o.we_spi_data,
                                              io_wr_o.we_spi_ctrl, io_wr_o.we_gfx_cmd,
                                              io_wr_o.we_res_flush, io_wr_o.we_fb_addr}))
            else $error("more than one I/O write strobe active");
    end

    // read data, same cycle as the request
    always_comb begin
        rdata_o = 32'd0;
        if (io_hit) begin
            case (slot)
                SLOT_MS:        rdata_o = status_i.ms_count;
                SLOT_UART_DATA: rdata_o = {24'd0, status_i.rx_byte};
                SLOT_UART_CTRL: rdata_o = {30'd0, status_i.tx_ready, status_i.rx_ready};
                SLOT_SPI_DATA:  rdata_o = status_i.spi_rx;
                SLOT_SPI_CTRL:  rdata_o = {31'd0, status_i.spi_ready};
                SLOT_GFX_CMD:   rdata_o = {31'd0, status_i.gfx_ready};
                SLOT_RES_FLUSH: rdata_o = {H_RES, V_RES};   // width high, height low
                SLOT_VSYNC:     rdata_o = {31'd0, status_i.vsync};
                default:        rdata_o = 32'd0;            // write-only and spare slots
            endcase
        end
    end

endmodule

// ==== design/ms_timer.sv ====
/* free-running millisecond counter driven by a sub-millisecond
   tick divider */

`timescale 1ns/1ps

module ms_timer
    import soc_map_pkg::*;
(
    input  logic        clk_cpu,
    input  logic        rst_n,
    output logic [31:0] ms_count_o
);

    logic [TICK_W-1:0] tick_q;  // cycles within the current ms
    logic              ms_wrap;

    assign ms_wrap = (tick_q == TICK_W'(TICKS_PER_MS - 1));

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            tick_q     <= '0;
            ms_count_o <= 32'd0;
        end else begin
            if (ms_wrap) begin
                tick_q     <= '0;
                ms_count_o <= ms_count_o + 32'd1;   // one per TICKS_PER_MS cycles
            end else begin
                tick_q <= tick_q + TICK_W'(1);
            end
        end
    end

endmodule

// ==== design/uart_rx_queue.sv ====
/* UART receive byte queue: edge-detected enqueue, registered
   pop on a dequeue strobe and the latched read byte */

`timescale 1ns/1ps

module uart_rx_queue
    import soc_map_pkg::*;
(
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic [7:0] rx_byte_i,
    input  logic       rx_valid_i,
    input  logic       deq_i,
    output logic [7:0] rx_data_o,
    output logic       rx_ready_o
);

    localparam int PTR_W = RXQ_DEPTH_LOG2 + 1;     // extra bit tells full from empty

    logic [7:0]       mem [RXQ_DEPTH];
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [PTR_W-1:0] level;
    logic [PTR_W-1:0] level_next;
    logic             rx_valid_q;   // previous receiver level
    logic             pop_q;        // pop pending from last cycle's dequeue
    logic             full;
    logic             push_ok;
    logic             deq_ok;

    assign level   = wptr_q - rptr_q;
    assign full    = (level == PTR_W'(RXQ_DEPTH));
    assign push_ok = rx_valid_i && !rx_valid_q && !full;    // rising edge only
    // a pending pop already claims one entry
    assign deq_ok  = deq_i && (level > PTR_W'(pop_q));

    assign level_next = level + PTR_W'(push_ok) - PTR_W'(pop_q);

    always_ff @(posedge clk_cpu) begin
        if (push_ok) begin
            mem[wptr_q[RXQ_DEPTH_LOG2-1:0]] <= rx_byte_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wptr_q     <= '0;
            rptr_q     <= '0;
            rx_valid_q <= 1'b0;
            pop_q      <= 1'b0;
            rx_ready_o <= 1'b0;
            rx_data_o  <= 8'd0;
        end else begin
            rx_valid_q <= rx_valid_i;
            pop_q      <= deq_ok;
            rx_ready_o <= (level_next != '0);
            if (push_ok) begin
                wptr_q <= wptr_q + PTR_W'(1);
            end
            if (pop_q) begin
                rx_data_o <= mem[rptr_q[RXQ_DEPTH_LOG2-1:0]];  // shows two cycles after deq
                rptr_q    <= rptr_q + PTR_W'(1);
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        pop_q |-> (wptr_q != rptr_q))
        else $error("rx queue popped while empty");

    // registered ready tracks the pointers
    a_ready_level: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        rx_ready_o == (wptr_q != rptr_q))
        else $error("rx ready disagrees with queue level");

endmodule

// ==== design/io_ctrl_regs.sv ====
/* writable control registers of the I/O block: LEDs, SPI control,
   drawing-engine command, frame base and the one-cycle pulses */

`timescale 1ns/1ps

module io_ctrl_regs
    import soc_map_pkg::*, soc_bus_pkg::*;
(
    input  logic        clk_cpu,
    input  logic        rst_n,
    input  io_wr_t      io_wr_i,
    input  logic [31:0] gfx_front_addr_i,
    output ctrl_out_t   ctrl_o,
    output logic        tx_start_o,
    output logic [7:0]  tx_data_o,
    output logic        spi_start_o,
    output logic [31:0] spi_tx_o
);

    logic [7:0]  led_q;
    logic [2:0]  spi_ctrl_q;    // [2] fast, [1:0] slave enables
    logic [31:0] gfx_data_q;
    logic        gfx_valid_q;
    logic        flush_q;
    logic [31:0] fb_addr_q;
    logic        use_front_q;   // engine owns the frame base

    // control state and pulses
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_q       <= 8'd0;
            spi_ctrl_q  <= 3'd0;
            gfx_valid_q <= 1'b0;
            flush_q     <= 1'b0;
            fb_addr_q   <= DEFAULT_FB_ADDR;
            use_front_q <= 1'b0;
            tx_start_o  <= 1'b0;
            spi_start_o <= 1'b0;
        end else begin
            tx_start_o  <= io_wr_i.we_uart_data;
            spi_start_o <= io_wr_i.we_spi_data;
            gfx_valid_q <= io_wr_i.we_gfx_cmd;
            flush_q     <= io_wr_i.we_res_flush && io_wr_i.wdata[0];
            if (io_wr_i.we_led) begin
                led_q <= io_wr_i.wdata[7:0];
            end
            if (io_wr_i.we_spi_ctrl) begin
                spi_ctrl_q <= io_wr_i.wdata[2:0];
            end
            if (io_wr_i.we_gfx_cmd) begin
                use_front_q <= 1'b1;            // engine takes over the base
            end else if (io_wr_i.we_fb_addr) begin
                fb_addr_q   <= io_wr_i.wdata;
                use_front_q <= 1'b0;
            end
        end
    end

    // data that travels with the pulses
    always_ff @(posedge clk_cpu) begin
        if (io_wr_i.we_uart_data) tx_data_o <= io_wr_i.wdata[7:0];
        if (io_wr_i.we_spi_data)  spi_tx_o <= io_wr_i.wdata;
        if (io_wr_i.we_gfx_cmd)   gfx_data_q <= io_wr_i.wdata;
    end

    always_comb begin
        ctrl_o.led           = led_q;
        ctrl_o.spi_ss_n      = ~spi_ctrl_q[1:0];   // active low
        ctrl_o.spi_fast      = spi_ctrl_q[2];
        ctrl_o.gfx_cmd_data  = gfx_data_q;
        ctrl_o.gfx_cmd_valid = gfx_valid_q;
        ctrl_o.flush         = flush_q;
        ctrl_o.frame_base    = use_front_q ? gfx_front_addr_i : fb_addr_q;
    end

    // software spaces engine commands by polling ready
    a_gfx_single: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        gfx_valid_q |=> !gfx_valid_q)
        else $error("back-to-back drawing engine commands");

endmodule

// ==== design/soc_io_top.sv ====
/* memory-mapped I/O block of the SoC: bus port, millisecond
   timer, UART receive queue and control registers */

`timescale 1ns/1ps

module soc_io_top
    import soc_bus_pkg::*;
(
    input  logic        clk_cpu,
    input  logic        rst_n,
    // CPU bus
    input  io_req_t     io_req_i,
    output logic [31:0] rdata_o,
    // UART
    input  logic [7:0]  rx_byte_i,
    input  logic        rx_valid_i,
    input  logic        tx_rdy_i,
    output logic        tx_start_o,
    output logic [7:0]  tx_data_o,
    // SPI
    input  logic [31:0] spi_rx_i,
    input  logic        spi_rdy_i,
    output logic        spi_start_o,
    output logic [31:0] spi_tx_o,
    // drawing engine and video
    input  logic        gfx_ready_i,
    input  logic [31:0] gfx_front_addr_i,
    input  logic        vsync_i,
    output ctrl_out_t   ctrl_o
);

    io_wr_t      io_wr;
    io_status_t  status;
    logic [31:0] ms_count;
    logic [7:0]  rx_data;
    logic        rx_ready;

    assign status.ms_count  = ms_count;
    assign status.rx_byte   = rx_data;
    assign status.rx_ready  = rx_ready;
    assign status.tx_ready  = tx_rdy_i;
    assign status.spi_rx    = spi_rx_i;
    assign status.spi_ready = spi_rdy_i;
    assign status.gfx_ready = gfx_ready_i;
    assign status.vsync     = vsync_i;

    io_bus_port u_bus_port (
        .io_req_i (io_req_i),
        .status_i (status),
        .io_wr_o  (io_wr),
        .rdata_o  (rdata_o)
    );

    ms_timer u_ms_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    uart_rx_queue u_rx_queue (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .rx_byte_i  (rx_byte_i),
        .rx_valid_i (rx_valid_i),
        .deq_i      (io_wr.we_uart_ctrl),
        .rx_data_o  (rx_data),
        .rx_ready_o (rx_ready)
    );

    io_ctrl_regs u_ctrl_regs (
        .clk_cpu          (clk_cpu),
        .rst_n            (rst_n),
        .io_wr_i          (io_wr),
        .gfx_front_addr_i (gfx_front_addr_i),
        .ctrl_o           (ctrl_o),
        .tx_start_o       (tx_start_o),
        .tx_data_o        (tx_data_o),
        .spi_start_o      (spi_start_o),
        .spi_tx_o         (spi_tx_o)
    );

endmodule

// ==== dv/soc_io_checks.svh ====
/* bus request tasks, error reporting and the reference
   function for the expected read word of each slot */

`ifndef SOC_IO_CHECKS_SVH
`define SOC_IO_CHECKS_SVH

function automatic io_req_t make_req(input logic we, input logic [4:0] slot,
                                     input logic [31:0] data);
    io_req_t req;
    req.sel   = 1'b1;
    req.we    = we;
    req.addr  = {IO_REGION, 21'd0, slot, 2'b00};   // word slot in bits 6:2
    req.wdata = data;
    return req;
endfunction

task automatic bus_write(input logic [4:0] slot, input logic [31:0] data);
    @(posedge clk_cpu);
    io_req <= make_req(1'b1, slot, data);
    @(posedge clk_cpu);
    io_req <= '0;
endtask

// read data is compared by the negedge process while sel is up
task automatic bus_read(input logic [4:0] slot);
    @(posedge clk_cpu);
    io_req <= make_req(1'b0, slot, 32'd0);
    @(posedge clk_cpu);
    io_req <= '0;
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_cpu);
endtask

task automatic report_error(input string msg);
    $display("ERROR %0d ns: %s", $time, msg);
    err_cnt++;
endtask

// expected read word from the slot and the model state
function automatic logic [31:0] expected_rdata(input logic [4:0] slot);
    logic [31:0] word;
    word = 32'd0;
    case (slot)
        5'd0:    word = run_cycles / TICKS_PER_MS;      // whole ms since reset
        5'd2:    word = {24'd0, m_rx_byte};
        5'd3:    word = {30'd0, tx_rdy, m_rx_ready};
        5'd4:    word = spi_rx;
        5'd5:    word = {31'd0, spi_rdy};
        5'd8:    word = {31'd0, gfx_ready};
        5'd9:    word = {16'd640, 16'd480};            // fixed 640x480 display
        5'd11:   word = {31'd0, vsync};
        default: word = 32'd0;
    endcase
    return word;
endfunction

`endif

// ==== dv/soc_io_tb.sv ====
/* testbench of the I/O block: clock, reset, six directed tests,
   read data comparison, pulse monitor and watchdog */

`timescale 1ns/1ps

module soc_io_tb
    import soc_map_pkg::*, soc_bus_pkg::*;
();

    localparam int WATCHDOG_CYCLES = 4 * TICKS_PER_MS;  // 2 ms counting plus margin
    localparam int RX_SLOTS        = 1 << RXQ_DEPTH_LOG2;

    logic        clk_cpu;
    logic        rst_n;
    io_req_t     io_req;
    logic [31:0] rdata;
    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        tx_rdy;
    logic        tx_start;
    logic [7:0]  tx_data;
    logic [31:0] spi_rx;
    logic        spi_rdy;
    logic        spi_start;
    logic [31:0] spi_tx;
    logic        gfx_ready;
    logic [31:0] gfx_front;
    logic        vsync;
    ctrl_out_t   ctrl;

    int          run_cycles;    // cycles since reset release
    logic [7:0]  rx_model [$];  // bytes the queue should hold
    logic [7:0]  m_rx_byte;
    logic        m_rx_ready;
    integer      seed;
    int          err_cnt;
    int          read_cnt;
    int          test_cnt;
    int          fail_cnt;
    int          test_err_base;
    string       cur_test;
    logic [4:0]  rd_slot;
    logic [31:0] exp_rdata;
    logic [31:0] last_rdata;
    int          tx_pulses;
    int          spi_pulses;
    int          gfx_pulses;
    int          flush_pulses;
    logic [7:0]  tx_seen;
    logic [31:0] spi_seen;
    logic [31:0] gfx_seen;
    logic [31:0] rnd;
    logic [31:0] wval;
    logic [31:0] prev_ms;
    int          i;
    int          k;

    `include "soc_io_checks.svh"

    soc_io_top uut (
        .clk_cpu          (clk_cpu),
        .rst_n            (rst_n),
        .io_req_i         (io_req),
        .rdata_o          (rdata),
        .rx_byte_i        (rx_byte),
        .rx_valid_i       (rx_valid),
        .tx_rdy_i         (tx_rdy),
        .tx_start_o       (tx_start),
        .tx_data_o        (tx_data),
        .spi_rx_i         (spi_rx),
        .spi_rdy_i        (spi_rdy),
        .spi_start_o      (spi_start),
        .spi_tx_o         (spi_tx),
        .gfx_ready_i      (gfx_ready),
        .gfx_front_addr_i (gfx_front),
        .vsync_i          (vsync),
        .ctrl_o           (ctrl)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #50 clk_cpu = ~clk_cpu;     // 100 ns period
    end

    always @(posedge clk_cpu) begin
        if (!rst_n) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    // compare every read against the reference model
    always @(negedge clk_cpu) begin
        if (rst_n && io_req.sel && !io_req.we) begin
            rd_slot    = io_req.addr[6:2];
            exp_rdata  = expected_rdata(rd_slot);
            last_rdata = rdata;
            read_cnt++;
            if (rd_slot == SLOT_MS) begin
                if (rdata > exp_rdata + 32'd1 || rdata + 32'd1 < exp_rdata) begin
                    report_error($sformatf("ms count %0d, expected %0d", rdata, exp_rdata));
                end
            end else if (rdata !== exp_rdata) begin
                report_error($sformatf("slot %0d read %h, expected %h",
                                       rd_slot, rdata, exp_rdata));
            end
        end
    end

    // count output pulses and keep their data
    always @(negedge clk_cpu) begin
        if (tx_start) begin
            tx_pulses++;
            tx_seen = tx_data;
        end
        if (spi_start) begin
            spi_pulses++;
            spi_seen = spi_tx;
        end
        if (ctrl.gfx_cmd_valid) begin
            gfx_pulses++;
            gfx_seen = ctrl.gfx_cmd_data;
        end
        if (ctrl.flush) begin
            flush_pulses++;
        end
    end

    task automatic clear_pulses();
        tx_pulses    = 0;
        spi_pulses   = 0;
        gfx_pulses   = 0;
        flush_pulses = 0;
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        int n;
        n = err_cnt - test_err_base;
        if (n != 0) begin
            fail_cnt++;
        end
        $display("test %-16s %s, %0d errors", cur_test, (n == 0) ? "ok" : "bad", n);
    endtask

    // one byte per rising edge of a valid level of random length
    task automatic send_rx_byte(input logic [7:0] value);
        int hold;
        int gap;
        hold = 1 + ($unsigned($random(seed)) % 4);
        gap  = $unsigned($random(seed)) % 3;
        @(posedge clk_cpu);
        rx_byte  <= value;
        rx_valid <= 1'b1;
        repeat (hold) @(posedge clk_cpu);
        rx_valid <= 1'b0;
        repeat (gap) @(posedge clk_cpu);
        if (rx_model.size() < RX_SLOTS) begin
            rx_model.push_back(value);  // a full queue drops the byte
        end
    endtask

    task automatic pop_and_check();
        bus_write(SLOT_UART_CTRL, 32'd1);
        if (rx_model.size() != 0) begin
            m_rx_byte = rx_model.pop_front();
        end
        m_rx_ready = (rx_model.size() != 0);
        bus_read(SLOT_UART_DATA);   // two cycles after the write
        bus_read(SLOT_UART_CTRL);
    endtask

    initial begin
        rst_n      = 1'b0;
        io_req     = '0;
        rx_byte    = 8'd0;
        rx_valid   = 1'b0;
        tx_rdy     = 1'b0;
        spi_rx     = 32'd0;
        spi_rdy    = 1'b0;
        gfx_ready  = 1'b0;
        gfx_front  = 32'd0;
        vsync      = 1'b0;
        seed       = 3;
        run_cycles = 0;
        m_rx_byte  = 8'd0;
        m_rx_ready = 1'b0;
        err_cnt    = 0;
        read_cnt   = 0;
        test_cnt   = 0;
        fail_cnt   = 0;
        clear_pulses();
        repeat (4) @(posedge clk_cpu);
        rst_n <= 1'b1;

        begin_test("reset state");
        wait_cycles(1);
        @(negedge clk_cpu);
        if (ctrl.led !== 8'd0 || ctrl.spi_ss_n !== 2'b11) begin
            report_error("led or slave selects not at reset value");
        end
        if (ctrl.frame_base !== DEFAULT_FB_ADDR) begin
            report_error($sformatf("frame base %h after reset", ctrl.frame_base));
        end
        if (tx_start || spi_start || ctrl.gfx_cmd_valid || ctrl.flush) begin
            report_error("pulse output high after reset");
        end
        bus_read(SLOT_MS);
        bus_read(SLOT_RES_FLUSH);
        end_test();

        begin_test("register writes");
        for (i = 0; i < 8; i++) begin
            wval = $random(seed);
            bus_write(SLOT_LED, wval);
            @(negedge clk_cpu);
            if (ctrl.led !== wval[7:0]) begin
                report_error($sformatf("led %h, expected %h", ctrl.led, wval[7:0]));
            end
            wval = $random(seed);
            bus_write(SLOT_SPI_CTRL, wval);
            @(negedge clk_cpu);
            if (ctrl.spi_ss_n !== ~wval[1:0] || ctrl.spi_fast !== wval[2]) begin
                report_error($sformatf("spi control wrong for write %h", wval[2:0]));
            end
        end
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            @(posedge clk_cpu);
            tx_rdy    <= rnd[0];
            spi_rdy   <= rnd[1];
            gfx_ready <= rnd[2];
            vsync     <= rnd[3];
            spi_rx    <= $random(seed);
            bus_read(SLOT_UART_CTRL);
            bus_read(SLOT_SPI_DATA);
            bus_read(SLOT_SPI_CTRL);
            bus_read(SLOT_GFX_CMD);
            bus_read(SLOT_VSYNC);
        end
        bus_read(5'd6);         // spare slots
        bus_read(5'd7);
        bus_read(5'd12);
        bus_read(5'd31);
        end_test();

        begin_test("pulses");
        wval = $random(seed);
        clear_pulses();
        bus_write(SLOT_UART_DATA, wval);
        wait_cycles(4);
        if (tx_pulses != 1 || tx_seen !== wval[7:0]) begin
            report_error($sformatf("tx start: %0d pulses, data %h", tx_pulses, tx_seen));
        end
        wval = $random(seed);
        clear_pulses();
        bus_write(SLOT_SPI_DATA, wval);
        wait_cycles(4);
        if (spi_pulses != 1 || spi_seen !== wval) begin
            report_error($sformatf("spi start: %0d pulses, data %h", spi_pulses, spi_seen));
        end
        wval = $random(seed);
        clear_pulses();
        bus_write(SLOT_GFX_CMD, wval);
        wait_cycles(4);
        if (gfx_pulses != 1 || gfx_seen !== wval) begin
            report_error($sformatf("gfx command: %0d pulses, data %h", gfx_pulses, gfx_seen));
        end
        clear_pulses();
        bus_write(SLOT_RES_FLUSH, $random(seed) | 32'd1);
        wait_cycles(4);
        if (flush_pulses != 1) begin
            report_error($sformatf("flush with bit 0 set: %0d pulses", flush_pulses));
        end
        clear_pulses();
        bus_write(SLOT_RES_FLUSH, $random(seed) & ~32'd1);
        wait_cycles(4);
        if (flush_pulses != 0) begin
            report_error($sformatf("flush with bit 0 clear: %0d pulses", flush_pulses));
        end
        end_test();

        begin_test("frame base");
        @(posedge clk_cpu);
        gfx_front <= $random(seed);
        wval = $random(seed);
        bus_write(SLOT_FB_ADDR, wval);
        @(negedge clk_cpu);
        if (ctrl.frame_base !== wval) begin
            report_error($sformatf("frame base %h, expected %h", ctrl.frame_base, wval));
        end
        bus_write(SLOT_GFX_CMD, 32'd0);
        @(negedge clk_cpu);
        if (ctrl.frame_base !== gfx_front) begin
            report_error($sformatf("frame base %h, expected front %h",
                                   ctrl.frame_base, gfx_front));
        end
        wval = $random(seed);
        bus_write(SLOT_FB_ADDR, wval);
        @(negedge clk_cpu);
        if (ctrl.frame_base !== wval) begin
            report_error($sformatf("frame base %h, expected %h", ctrl.frame_base, wval));
        end
        end_test();

        begin_test("uart queue");
        for (i = 0; i < 6; i++) begin
            rnd = $random(seed);
            send_rx_byte(rnd[7:0]);
        end
        wait_cycles(2);
        m_rx_ready = (rx_model.size() != 0);
        bus_read(SLOT_UART_CTRL);
        while (rx_model.size() != 0) begin
            pop_and_check();
        end
        pop_and_check();        // dequeue on empty keeps the last byte
        for (i = 0; i < RX_SLOTS + 1; i++) begin
            rnd = $random(seed);
            send_rx_byte(rnd[7:0]);
        end
        wait_cycles(2);
        m_rx_ready = 1'b1;
        bus_read(SLOT_UART_CTRL);
        while (rx_model.size() != 0) begin
            pop_and_check();
        end
        end_test();

        begin_test("ms counter");
        bus_read(SLOT_MS);
        prev_ms = last_rdata;
        for (k = 0; k < 2; k++) begin
            wait_cycles(TICKS_PER_MS - 2);  // reads exactly one ms apart
            bus_read(SLOT_MS);
            if (last_rdata - prev_ms > 32'd2) begin
                report_error($sformatf("ms count went from %0d to %0d", prev_ms, last_rdata));
            end
            prev_ms = last_rdata;
        end
        end_test();

        $display("tests %0d, failing tests %0d, reads compared %0d, errors %0d",
                 test_cnt, fail_cnt, read_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== soc_io.f ====
+incdir+dv
design/soc_map_pkg.sv
design/soc_bus_pkg.sv
design/io_bus_port.sv
design/ms_timer.sv
design/uart_rx_queue.sv
design/io_ctrl_regs.sv
design/soc_io_top.sv
dv/soc_io_tb.sv

// ==== Bender.yml ====
package:
  name: soc_io

sources:
  # packages first, then the modules that import them
  - files:
      - design/soc_map_pkg.sv
      - design/soc_bus_pkg.sv
      - design/io_bus_port.sv
      - design/ms_timer.sv
      - design/uart_rx_queue.sv
      - design/io_ctrl_regs.sv
      - design/soc_io_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/soc_io_tb.sv
